//--- Makefile
VERILATOR  := verilator
TOP        := bar_tb
RTL_TOP    := bar_top
FILELIST   := pcie_bar4k.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS

VFLAGS     := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		common/bar_pkg.sv bar_mem/bar_ram.sv bar_mem/bar_rd_pipe.sv design/bar_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bar_mem/bar_ram.sv
`timescale 1ns/10ps

module bar_ram
    import bar_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = BAR_DEPTH_WORDS
) (
    input  logic                           clk,

    // write port
    input  logic                           wr_en,
    input  logic [$clog2(DEPTH_WORDS)-1:0] wr_idx,
    input  bar_be_t                        wr_be,
    input  bar_data_t                      wr_data,

    // read port, two cycles of latency
    input  logic                           rd_en,
    input  logic [$clog2(DEPTH_WORDS)-1:0] rd_idx,
    output bar_data_t                      rd_data
);

    localparam int unsigned IDX_W   = $clog2(DEPTH_WORDS);
    localparam int unsigned N_LANES = $bits(bar_be_t);

    typedef logic [IDX_W-1:0] word_idx_t;

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------

    // whole window reads as zero until written
    bar_data_t mem [DEPTH_WORDS] = '{default: '0};

    // first read stage
    bar_data_t rd_stage1;
    logic      rd_stage1_valid;

    word_idx_t wr_word;
    word_idx_t rd_word;

    assign wr_word = wr_idx;
    assign rd_word = rd_idx;

    // ------------------------------------------------------------------
    // array access
    // ------------------------------------------------------------------

    // the read samples the array before the write of the same edge
    // lands, so a read and write to one word return the old value
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_stage1 <= mem[rd_word];
        end

        for (int lane = 0; lane < N_LANES; lane++) begin
            if (wr_en && wr_be[lane]) begin
                mem[wr_word][lane*8 +: 8] <= wr_data[lane*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------------

    // marks that stage 1 holds a fresh word
    always_ff @(posedge clk) begin
        rd_stage1_valid <= rd_en;
    end

    // hold the last word when no read is in flight
    always_ff @(posedge clk) begin
        if (rd_stage1_valid) begin
            rd_data <= rd_stage1;
        end
    end

endmodule

//--- bar_mem/bar_rd_pipe.sv
`timescale 1ns/10ps

module bar_rd_pipe
    import bar_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // read request side
    input  logic     req_valid,
    input  bar_ctx_t req_ctx,

    // delayed by two cycles, in step with bar_ram
    output logic     rsp_valid,
    output bar_ctx_t rsp_ctx
);

    // ------------------------------------------------------------------
    // stage 1
    // ------------------------------------------------------------------

    logic     stage1_valid;
    bar_ctx_t stage1_ctx;

    // ------------------------------------------------------------------
    // valid chain
    // ------------------------------------------------------------------

    // no response may leave in the two cycles after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            rsp_valid    <= 1'b0;
        end else begin
            stage1_valid <= req_valid;
            rsp_valid    <= stage1_valid;
        end
    end

    // ------------------------------------------------------------------
    // context chain
    // ------------------------------------------------------------------

    // each stage owns its own context, so two reads in flight
    // keep their completions apart
    always_ff @(posedge clk) begin
        stage1_ctx <= req_ctx;
        rsp_ctx    <= stage1_ctx;
    end

endmodule

//--- common/bar_pkg.sv
package bar_pkg;

    // ------------------------------------------------------------------
    // BAR geometry
    // ------------------------------------------------------------------

    // 4 KiB window of 32-bit words
    localparam int unsigned BAR_DEPTH_WORDS = 1024;

    localparam int unsigned BAR_ADDR_W = 32;
    localparam int unsigned BAR_DATA_W = 32;
    localparam int unsigned BAR_BE_W   = BAR_DATA_W / 8;
    localparam int unsigned BAR_CTX_W  = 88;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------

    // byte offset as delivered by the TLP decoder
    typedef logic [BAR_ADDR_W-1:0] bar_addr_t;

    typedef logic [BAR_DATA_W-1:0] bar_data_t;

    // bit n enables byte n
    typedef logic [BAR_BE_W-1:0]   bar_be_t;

    // completion context, opaque to the BAR
    typedef logic [BAR_CTX_W-1:0]  bar_ctx_t;

    // ------------------------------------------------------------------
    // request and response bundles
    // ------------------------------------------------------------------

    typedef struct packed {
        logic      valid;
        bar_addr_t addr;
        bar_be_t   be;
        bar_data_t data;
    } bar_wr_req_t;

    typedef struct packed {
        logic      valid;
        bar_ctx_t  ctx;
        bar_addr_t addr;
    } bar_rd_req_t;

    typedef struct packed {
        logic      valid;
        bar_ctx_t  ctx;
        bar_data_t data;
    } bar_rd_rsp_t;

endpackage

//--- design/bar_top.sv
`timescale 1ns/10ps

module bar_top
    import bar_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = BAR_DEPTH_WORDS
) (
    input  logic        clk,
    input  logic        rst,

    // incoming writes, one per cycle
    input  bar_wr_req_t wr,

    // incoming reads, one per cycle
    input  bar_rd_req_t rd_req,

    // completions, always accepted
    output bar_rd_rsp_t rd_rsp
);

    localparam int unsigned IDX_W = $clog2(DEPTH_WORDS);

    typedef logic [IDX_W-1:0] word_idx_t;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------

    word_idx_t wr_idx;
    word_idx_t rd_idx;

    // drop the byte bits and anything above the window
    assign wr_idx = wr.addr[IDX_W+1:2];
    assign rd_idx = rd_req.addr[IDX_W+1:2];

    // ------------------------------------------------------------------
    // memory
    // ------------------------------------------------------------------

    bar_data_t ram_rd_data;

    bar_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) bar_ram_i (
        .clk     (clk),
        .wr_en   (wr.valid),
        .wr_idx  (wr_idx),
        .wr_be   (wr.be),
        .wr_data (wr.data),
        .rd_en   (rd_req.valid),
        .rd_idx  (rd_idx),
        .rd_data (ram_rd_data)
    );

    // ------------------------------------------------------------------
    // completion context
    // ------------------------------------------------------------------

    logic     pipe_valid;
    bar_ctx_t pipe_ctx;

    bar_rd_pipe bar_rd_pipe_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (rd_req.valid),
        .req_ctx   (rd_req.ctx),
        .rsp_valid (pipe_valid),
        .rsp_ctx   (pipe_ctx)
    );

    // ------------------------------------------------------------------
    // response assembly
    // ------------------------------------------------------------------

    // memory output holds stale words between reads, so mask it
    always_comb begin
        rd_rsp.valid = pipe_valid;
        rd_rsp.ctx   = pipe_ctx;
        rd_rsp.data  = pipe_valid ? ram_rd_data : '0;
    end

endmodule

//--- pcie_bar4k.f
+incdir+verif
common/bar_pkg.sv
bar_mem/bar_ram.sv
bar_mem/bar_rd_pipe.sv
design/bar_top.sv
verif/bar_tb.sv

//--- verif/bar_tb_model.svh
`ifndef BAR_TB_MODEL_SVH
`define BAR_TB_MODEL_SVH

// ----------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------

// x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'h3424;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// one step per bit
function automatic logic [31:0] rand_word();
    logic [31:0] v;
    for (int i = 0; i < 32; i++) begin
        v[i] = lfsr_bit();
    end
    return v;
endfunction

function automatic bar_be_t rand_be();
    bar_be_t v;
    for (int i = 0; i < $bits(bar_be_t); i++) begin
        v[i] = lfsr_bit();
    end
    return v;
endfunction

function automatic bar_ctx_t rand_ctx();
    bar_ctx_t v;
    for (int i = 0; i < $bits(bar_ctx_t); i++) begin
        v[i] = lfsr_bit();
    end
    return v;
endfunction

// ----------------------------------------------------------------------
// reference memory
// ----------------------------------------------------------------------

// every word starts at zero
bar_data_t model_mem [DEPTH_WORDS] = '{default: '0};

// word offset, folded into the window
function automatic int unsigned model_index(bar_addr_t addr);
    return (addr >> 2) % DEPTH_WORDS;
endfunction

// call before model_write of the same edge
function automatic bar_data_t expected_data(bar_addr_t addr);
    return model_mem[model_index(addr)];
endfunction

function automatic void model_write(bar_addr_t addr, bar_be_t be, bar_data_t data);
    int unsigned idx;
    idx = model_index(addr);
    for (int b = 0; b < $bits(bar_be_t); b++) begin
        if (be[b]) begin
            model_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
    end
endfunction

// ----------------------------------------------------------------------
// expected responses
// ----------------------------------------------------------------------

typedef struct packed {
    logic [31:0] test_id;
    logic [31:0] due_edge;
    bar_ctx_t    ctx;
    bar_data_t   data;
} exp_rsp_t;

// oldest read first
exp_rsp_t exp_q [$];

function automatic void push_expected(
    int unsigned test_id,
    int unsigned due_edge,
    bar_ctx_t    ctx,
    bar_data_t   data
);
    exp_rsp_t e;
    e.test_id  = test_id;
    e.due_edge = due_edge;
    e.ctx      = ctx;
    e.data     = data;
    exp_q.push_back(e);
endfunction

`endif

//--- verif/bar_tb.sv
`timescale 1ns/10ps

module bar_tb
    import bar_pkg::*;
();

    // ------------------------------------------------------------------
    // run length
    // ------------------------------------------------------------------

    localparam int unsigned DEPTH_WORDS     = BAR_DEPTH_WORDS;
    localparam int unsigned CLK_PERIOD_NS   = 100;
    localparam int unsigned RST_CYCLES      = 10;
    localparam int unsigned RD_LATENCY      = 2;
    localparam int unsigned N_RANDOM        = 2000;
    // upper bound on the directed tests with their drains
    localparam int unsigned DIRECTED_CYCLES = 300;
    localparam int unsigned MARGIN_CYCLES   = 200;
    localparam int unsigned WATCHDOG_NS     =
        (RST_CYCLES + DIRECTED_CYCLES + N_RANDOM + MARGIN_CYCLES) * CLK_PERIOD_NS;

    localparam int unsigned T_RESET  = 1;
    localparam int unsigned T_FULL   = 2;
    localparam int unsigned T_BYTES  = 3;
    localparam int unsigned T_RDWR   = 4;
    localparam int unsigned T_RANDOM = 5;

    logic        clk = 1'b0;
    logic        rst;
    bar_wr_req_t wr;
    bar_rd_req_t rd_req;
    bar_rd_rsp_t rd_rsp;

    // rising edges seen so far
    int unsigned edge_no  = 0;
    int unsigned cur_test = T_RESET;

    `include "bar_tb_model.svh"

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    bar_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) bar_top_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

    // ------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------

    function automatic string test_name(int unsigned id);
        case (id)
            T_RESET:  return "reset_idle";
            T_FULL:   return "full_word";
            T_BYTES:  return "byte_enables";
            T_RDWR:   return "read_during_write";
            T_RANDOM: return "random_traffic";
            default:  return "unknown";
        endcase
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare_data(input int unsigned id, input bar_data_t exp, input bar_data_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("MISMATCH test %s data expected %h actual %h",
                test_name(id), exp, act));
        end
    endtask

    task automatic compare_ctx(input int unsigned id, input bar_ctx_t exp, input bar_ctx_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("MISMATCH test %s ctx expected %h actual %h",
                test_name(id), exp, act));
        end
    endtask

    // valid must be high exactly when a read is due
    task automatic check_no_rsp(input int unsigned id, input logic rsp_valid,
                                input logic rsp_due);
        if (rsp_valid !== rsp_due) begin
            if (rsp_due) begin
                stop_with_failure($sformatf("test %s: read response missing at edge %0d",
                    test_name(id), edge_no));
            end else begin
                stop_with_failure($sformatf(
                    "test %s: response valid %b at edge %0d with no read due",
                    test_name(id), rsp_valid, edge_no));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // drivers, all on the falling edge
    // ------------------------------------------------------------------

    task automatic drive_cycle(
        input logic      do_wr,
        input bar_addr_t wr_addr,
        input bar_be_t   wr_be,
        input bar_data_t wr_data,
        input logic      do_rd,
        input bar_addr_t rd_addr,
        input bar_ctx_t  ctx
    );
        @(negedge clk);
        // the read sees the word before this write
        if (do_rd) begin
            push_expected(cur_test, edge_no + 1 + RD_LATENCY, ctx, expected_data(rd_addr));
        end
        if (do_wr) begin
            model_write(wr_addr, wr_be, wr_data);
        end
        wr.valid     = do_wr;
        wr.addr      = wr_addr;
        wr.be        = wr_be;
        wr.data      = wr_data;
        rd_req.valid = do_rd;
        rd_req.ctx   = ctx;
        rd_req.addr  = rd_addr;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic write_word(input bar_addr_t addr, input bar_be_t be, input bar_data_t data);
        drive_cycle(1'b1, addr, be, data, 1'b0, '0, '0);
    endtask

    task automatic read_word(input bar_addr_t addr);
        drive_cycle(1'b0, '0, '0, '0, 1'b1, addr, rand_ctx());
    endtask

    task automatic wait_drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------

    task automatic run_reset_idle();
        cur_test = T_RESET;
        // nothing asked, nothing answered
        repeat (8) idle_cycle();
        read_word(32'h0000_0000);
        read_word(32'h0000_0FFC);
        for (int n = 0; n < 8; n++) begin
            read_word(rand_word());
        end
        wait_drain();
    endtask

    task automatic run_full_word();
        cur_test = T_FULL;
        write_word(32'h0000_0010, 4'hF, 32'hDEAD_BEEF);
        read_word(32'h0000_0010);
        // same word through byte bits and bits above the window
        read_word(32'h0000_0013);
        read_word(32'h0000_1010);
        read_word(32'hFFFF_F011);
        read_word(32'h0000_0014);
        wait_drain();
    endtask

    task automatic run_byte_enables();
        cur_test = T_BYTES;
        write_word(32'h0000_0020, 4'hF, 32'h1122_3344);
        write_word(32'h0000_0020, 4'b0001, 32'hAAAA_AAAA);
        read_word(32'h0000_0020);
        write_word(32'h0000_0020, 4'b0110, 32'hBBBB_BBBB);
        read_word(32'h0000_0020);
        write_word(32'h0000_0020, 4'b1000, 32'hCCCC_CCCC);
        read_word(32'h0000_0020);
        for (int be_val = 0; be_val < 16; be_val++) begin
            write_word(32'h0000_0040, be_val[3:0], rand_word());
            read_word(32'h0000_0040);
        end
        wait_drain();
    endtask

    task automatic run_read_during_write();
        cur_test = T_RDWR;
        write_word(32'h0000_0080, 4'hF, 32'h5555_AAAA);
        idle_cycle();
        drive_cycle(1'b1, 32'h0000_0080, 4'hF, 32'h1234_5678, 1'b1, 32'h0000_0080, rand_ctx());
        read_word(32'h0000_0080);
        drive_cycle(1'b1, 32'h0000_0080, 4'b0011, 32'hFFFF_FFFF, 1'b1, 32'h0000_0083, rand_ctx());
        read_word(32'h0000_0080);
        wait_drain();
    endtask

    task automatic run_random_traffic();
        logic      do_wr;
        bar_addr_t wr_addr;
        bar_addr_t rd_addr;
        bar_be_t   be;
        bar_data_t data;
        bar_ctx_t  ctx;
        cur_test = T_RANDOM;
        for (int n = 0; n < N_RANDOM; n++) begin
            do_wr   = lfsr_bit();
            wr_addr = rand_word();
            rd_addr = rand_word();
            be      = rand_be();
            data    = rand_word();
            ctx     = rand_ctx();
            // crowd half the traffic into 16 words so reads hit recent writes
            if (lfsr_bit()) begin
                wr_addr[11:6] = '0;
                rd_addr[11:6] = '0;
            end
            drive_cycle(do_wr, wr_addr, be, data, 1'b1, rd_addr, ctx);
        end
        wait_drain();
    endtask

    // ------------------------------------------------------------------
    // processes
    // ------------------------------------------------------------------

    initial begin : stimulus
        wr     = '0;
        rd_req = '0;
        rst    = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_reset_idle();
        run_full_word();
        run_byte_enables();
        run_read_during_write();
        run_random_traffic();

        repeat (4) idle_cycle();
        $display("Simulation finished: PASS");
        $finish;
    end

    // samples just after each rising edge, once the outputs have settled
    initial begin : rsp_check
        exp_rsp_t front;
        logic     due;
        forever begin
            @(posedge clk);
            #1;
            edge_no = edge_no + 1;
            due = 1'b0;
            // what settles after this edge is what the next edge samples
            if (exp_q.size() != 0) begin
                due = (exp_q[0].due_edge == edge_no + 1);
            end
            check_no_rsp(cur_test, rd_rsp.valid, due);
            if (due) begin
                front = exp_q.pop_front();
                compare_data(front.test_id, front.data, rd_rsp.data);
                compare_ctx(front.test_id, front.ctx, rd_rsp.ctx);
            end else begin
                // data reads as zero between responses
                compare_data(cur_test, '0, rd_rsp.data);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("watchdog expired after %0d ns, tests did not complete",
            WATCHDOG_NS));
    end

endmodule
